// ==== lc4_core.f ====
verilog/lc4_isa_pkg.sv
verilog/lc4_pipe_pkg.sv
verilog/lc4_fetch.sv
verilog/lc4_decoder.sv
verilog/lc4_regfile.sv
verilog/lc4_hazard.sv
verilog/lc4_execute.sv
verilog/lc4_core.sv
test/lc4_store_checker.sv
test/tb_lc4_core.sv

// ==== test/lc4_store_checker.sv ====
`timescale 1ns/1ps

module lc4_store_checker (
   input  logic               gwe,
   input  logic               i_arst_n,
   input  lc4_isa_pkg::word_t i_imem_addr,
   input  logic               i_dmem_we,
   input  lc4_isa_pkg::word_t i_dmem_addr,
   input  lc4_isa_pkg::word_t i_dmem_wdata
);
   import lc4_isa_pkg::*;

   // expected stores in program order
   word_t exp_addr[$];
   word_t exp_data[$];
   int    value_errors;
   int    missing_errors;
   int    extra_errors;
   int    reset_errors;

   initial begin
      value_errors   = 0;
      missing_errors = 0;
      extra_errors   = 0;
      reset_errors   = 0;
   end

   function automatic void expect_store(input word_t addr, input word_t data);
      exp_addr.push_back(addr);
      exp_data.push_back(data);
   endfunction

   task automatic clear_expected();
      exp_addr.delete();
      exp_data.delete();
   endtask

   function automatic int pending();
      return exp_addr.size();
   endfunction

   task automatic report_missing();
      if (exp_addr.size() > 0) begin
         $display("%0d expected stores never happened, next one to address %h at time %0t",
                  exp_addr.size(), exp_addr[0], $time);
         missing_errors = missing_errors + exp_addr.size();
      end
   endtask

   // reset state seen just as reset lifts on a falling edge
   always @(posedge i_arst_n) begin
      if (i_imem_addr !== RESET_PC) begin
         $display("[FAIL] %0t o_imem_addr expected %h got %h",
                  $time, RESET_PC, i_imem_addr);
         reset_errors = reset_errors + 1;
      end
      if (i_dmem_we !== 1'b0) begin
         $display("[FAIL] %0t o_dmem_we expected 0 got %b", $time, i_dmem_we);
         reset_errors = reset_errors + 1;
      end
   end

   // outputs are stable mid-cycle and the write lands at the next rising edge
   always @(negedge gwe) begin
      word_t a;
      word_t d;
      if (i_arst_n && i_dmem_we) begin
         if (exp_addr.size() == 0) begin
            $display("unexpected store of %h to address %h at time %0t",
                     i_dmem_wdata, i_dmem_addr, $time);
            extra_errors = extra_errors + 1;
         end else begin
            a = exp_addr.pop_front();
            d = exp_data.pop_front();
            if (i_dmem_addr !== a) begin
               $display("[FAIL] %0t o_dmem_addr expected %h got %h", $time, a, i_dmem_addr);
               value_errors = value_errors + 1;
            end
            if (i_dmem_wdata !== d) begin
               $display("[FAIL] %0t o_dmem_wdata expected %h got %h", $time, d, i_dmem_wdata);
               value_errors = value_errors + 1;
            end
         end
      end
   end

endmodule

// ==== test/tb_lc4_core.sv ====
`timescale 1ns/1ps

module tb_lc4_core;
   import lc4_isa_pkg::*;

   localparam int MAX_LEN    = 48;
   localparam int BODY_LEN   = 28;
   localparam int NUM_DIR    = 5;
   localparam int NUM_RAND   = 20;
   localparam int NUM_PROGS  = NUM_DIR + NUM_RAND;
   localparam int DRAIN_CYC  = 8;
   // instructions x 4 + 40 per program plus reset and drain cycles
   localparam int WDOG_CYC   = NUM_PROGS * (MAX_LEN * 4 + 40 + DRAIN_CYC + 4);

   logic  gwe;
   logic  i_arst_n;
   word_t o_imem_addr;
   word_t i_imem_data;
   word_t o_dmem_addr;
   logic  o_dmem_we;
   word_t o_dmem_wdata;
   word_t i_dmem_rdata;

   word_t prog [MAX_LEN];
   int    prog_len;
   word_t dmem [65536];
   word_t ref_mem [65536];

   lc4_core #(.P_RESET_PC(RESET_PC)) dut0 (
      .gwe(gwe), .i_arst_n(i_arst_n), .o_imem_addr(o_imem_addr), .i_imem_data(i_imem_data),
      .o_dmem_addr(o_dmem_addr), .o_dmem_we(o_dmem_we), .o_dmem_wdata(o_dmem_wdata),
      .i_dmem_rdata(i_dmem_rdata)
   );

   lc4_store_checker chk0 (
      .gwe(gwe), .i_arst_n(i_arst_n), .i_imem_addr(o_imem_addr), .i_dmem_we(o_dmem_we),
      .i_dmem_addr(o_dmem_addr), .i_dmem_wdata(o_dmem_wdata)
   );

   initial begin
      gwe = 1'b0;
      forever #2 gwe = ~gwe;
   end

   // byte swap so every address bit shows up in the data
   function automatic word_t fill_value(input int a);
      word_t w;
      w = word_t'(a);
      return {w[7:0], w[15:8]} ^ 16'h5c3a;
   endfunction

   // memory models driven on the falling edge
   always @(negedge gwe) begin
      int idx;
      if (i_arst_n && o_dmem_we) begin
         dmem[o_dmem_addr] = o_dmem_wdata;
      end
      i_dmem_rdata = dmem[o_dmem_addr];
      idx = int'(o_imem_addr) - int'(RESET_PC);
      i_imem_data = (idx >= 0 && idx < MAX_LEN) ? prog[idx] : 16'h0000;
   end

   // instruction encoders
   function automatic word_t arith_rr(input int rd, input int rs, input int sb, input int rt);
      return {4'b0001, 3'(rd), 3'(rs), 3'(sb), 3'(rt)};
   endfunction

   function automatic word_t logic_rr(input int rd, input int rs, input int sb, input int rt);
      return {4'b0101, 3'(rd), 3'(rs), 3'(sb), 3'(rt)};
   endfunction

   function automatic word_t add_imm(input int rd, input int rs, input int imm);
      return {4'b0001, 3'(rd), 3'(rs), 1'b1, 5'(imm)};
   endfunction

   function automatic word_t const_insn(input int rd, input int imm);
      return {4'b1001, 3'(rd), 9'(imm)};
   endfunction

   function automatic word_t load_insn(input int rd, input int rs, input int imm);
      return {4'b0110, 3'(rd), 3'(rs), 6'(imm)};
   endfunction

   function automatic word_t store_insn(input int rt, input int rs, input int imm);
      return {4'b0111, 3'(rt), 3'(rs), 6'(imm)};
   endfunction

   function automatic word_t branch_insn(input int mask, input int off);
      return {4'b0000, 3'(mask), 9'(off)};
   endfunction

   task automatic put_insn(input word_t insn);
      prog[prog_len] = insn;
      prog_len = prog_len + 1;
   endtask

   // dump all registers relative to r0, then pad with nops
   task automatic finish_program();
      put_insn(store_insn(0, 0, 0));
      for (int i = 1; i < NUM_REGS; i++) begin
         put_insn(store_insn(i, 0, i));
      end
      while (prog_len < MAX_LEN) begin
         put_insn(16'h0000);
      end
   endtask

   function automatic nzp_t nzp_value(input word_t v);
      if (v == 16'h0000) begin
         return 3'b010;
      end
      return v[15] ? 3'b100 : 3'b001;
   endfunction

   // isa model of the kept subset that fills the checker's expected store list
   function automatic void run_reference();
      word_t r [8];
      nzp_t  nzp;
      int    idx;
      int    steps;
      int    off;
      word_t insn;
      word_t val;
      word_t addr;
      logic  wr;
      for (int i = 0; i < 8; i++) begin
         r[i] = 16'h0000;
      end
      nzp = 3'b010;
      idx = 0;
      steps = 0;
      while (idx >= 0 && idx < prog_len && steps < 4 * MAX_LEN) begin
         insn = prog[idx];
         idx = idx + 1;
         steps = steps + 1;
         wr = 1'b0;
         addr = r[insn[8:6]] + {{10{insn[5]}}, insn[5:0]};
         case (insn[15:12])
            4'b0000: begin
               off = $signed(insn[8:0]);
               if ((insn[11:9] & nzp) != 3'b000) begin
                  idx = idx + off;
               end
            end
            4'b0001: begin
               wr = 1'b1;
               if (insn[5]) begin
                  val = r[insn[8:6]] + {{11{insn[4]}}, insn[4:0]};
               end else if (insn[5:3] == 3'b000) begin
                  val = r[insn[8:6]] + r[insn[2:0]];
               end else if (insn[5:3] == 3'b010) begin
                  val = r[insn[8:6]] - r[insn[2:0]];
               end else begin
                  wr = 1'b0;
               end
            end
            4'b0101: begin
               wr = !insn[5];
               case (insn[5:3])
                  3'b000: val = r[insn[8:6]] & r[insn[2:0]];
                  3'b010: val = r[insn[8:6]] | r[insn[2:0]];
                  3'b011: val = r[insn[8:6]] ^ r[insn[2:0]];
                  default: wr = 1'b0;
               endcase
            end
            4'b0110: begin
               wr = 1'b1;
               val = ref_mem[addr];
            end
            4'b0111: begin
               ref_mem[addr] = r[insn[11:9]];
               chk0.expect_store(addr, r[insn[11:9]]);
            end
            4'b1001: begin
               wr = 1'b1;
               val = {{7{insn[8]}}, insn[8:0]};
            end
            default: ;
         endcase
         if (wr) begin
            r[insn[11:9]] = val;
            nzp = nzp_value(val);
         end
      end
   endfunction

   task automatic build_directed(input int n);
      prog_len = 0;
      case (n)
         // dependent arithmetic over the bypass paths
         0: begin
            put_insn(const_insn(1, 5));
            put_insn(const_insn(2, -3));
            put_insn(arith_rr(3, 1, 0, 2));
            put_insn(arith_rr(4, 3, 2, 1));
            put_insn(add_imm(5, 4, 7));
            put_insn(arith_rr(6, 5, 0, 5));
            put_insn(arith_rr(7, 6, 2, 3));
            put_insn(add_imm(0, 7, -1));
         end
         // logic ops, a mul and a shift must not write anything
         1: begin
            put_insn(const_insn(1, 170));
            put_insn(const_insn(2, -86));
            put_insn(logic_rr(3, 1, 0, 2));
            put_insn(arith_rr(3, 1, 1, 2));
            put_insn({4'b1010, 3'd6, 3'd1, 6'd3});
            put_insn(logic_rr(4, 1, 2, 2));
            put_insn(logic_rr(5, 4, 3, 1));
            put_insn(const_insn(0, 100));
         end
         // load followed by its user
         2: begin
            put_insn(const_insn(1, 16));
            put_insn(load_insn(2, 1, 3));
            put_insn(arith_rr(3, 2, 0, 2));
            put_insn(load_insn(4, 1, -2));
            put_insn(add_imm(5, 4, 1));
            put_insn(load_insn(1, 1, 0));
            put_insn(load_insn(6, 1, 0));
            put_insn(const_insn(0, 64));
         end
         // load then store of the loaded register
         3: begin
            put_insn(const_insn(1, 40));
            put_insn(load_insn(2, 1, 1));
            put_insn(store_insn(2, 1, 5));
            put_insn(load_insn(3, 1, 2));
            put_insn(const_insn(7, 1));
            put_insn(store_insn(3, 1, 6));
            put_insn(load_insn(4, 1, 7));
            put_insn(load_insn(5, 1, 5));
            put_insn(const_insn(0, 80));
         end
         // branches right after nzp writers with stores in the flushed slots
         default: begin
            put_insn(const_insn(1, -1));
            put_insn(branch_insn(3'b100, 1));
            put_insn(const_insn(2, 9));
            put_insn(const_insn(3, 3));
            put_insn(branch_insn(3'b010, 1));
            put_insn(add_imm(3, 3, -3));
            put_insn(branch_insn(3'b010, 2));
            put_insn(store_insn(1, 3, 1));
            put_insn(store_insn(1, 3, 2));
            put_insn(const_insn(6, 20));
            put_insn(load_insn(5, 6, 0));
            put_insn(branch_insn(3'b100, 1));
            put_insn(const_insn(7, 1));
            put_insn(load_insn(5, 6, 1));
            put_insn(branch_insn(3'b001, 1));
            put_insn(const_insn(7, 2));
            put_insn(branch_insn(3'b111, 1));
            put_insn(store_insn(6, 6, 3));
            put_insn(arith_rr(0, 1, 0, 1));
            // negative result, so this brp falls through
            put_insn(branch_insn(3'b001, 1));
            put_insn(add_imm(4, 4, 5));
         end
      endcase
      finish_program();
   endtask

   // branches only jump forward and never past the final stores
   task automatic build_random();
      int rd;
      int rs;
      int rt;
      prog_len = 0;
      for (int i = 0; i < BODY_LEN; i++) begin
         rd = $urandom % 8;
         rs = $urandom % 8;
         rt = $urandom % 8;
         case ($urandom % 10)
            0: put_insn(arith_rr(rd, rs, 0, rt));
            1: put_insn(arith_rr(rd, rs, 2, rt));
            2: put_insn(add_imm(rd, rs, $urandom % 32));
            3: put_insn(logic_rr(rd, rs, 0, rt));
            4: put_insn(logic_rr(rd, rs, 2, rt));
            5: put_insn(logic_rr(rd, rs, 3, rt));
            6: put_insn(const_insn(rd, $urandom % 512));
            7: put_insn(load_insn(rd, rs, $urandom % 64));
            8: put_insn(store_insn(rd, rs, $urandom % 64));
            default: put_insn(branch_insn($urandom % 7 + 1, $urandom % (BODY_LEN - i)));
         endcase
      end
      finish_program();
   endtask

   task automatic run_program();
      int cycles;
      @(negedge gwe);
      i_arst_n = 1'b0;
      chk0.clear_expected();
      for (int i = 0; i < 65536; i++) begin
         dmem[i] = fill_value(i);
         ref_mem[i] = fill_value(i);
      end
      run_reference();
      repeat (2) @(negedge gwe);
      i_arst_n = 1'b1;
      cycles = 0;
      while (chk0.pending() > 0 && cycles < prog_len * 4 + 40) begin
         @(negedge gwe);
         cycles = cycles + 1;
      end
      chk0.report_missing();
      // extra stores after the last expected one still get caught here
      repeat (DRAIN_CYC) @(negedge gwe);
   endtask

   initial begin
      #(WDOG_CYC * 4);
      $display("watchdog expired before all programs finished");
      $display("TEST FAILED");
      $finish;
   end

   initial begin
      int total;
      i_arst_n = 1'b0;
      i_imem_data = 16'h0000;
      i_dmem_rdata = 16'h0000;
      prog_len = 0;
      for (int i = 0; i < MAX_LEN; i++) begin
         prog[i] = 16'h0000;
      end
      void'($urandom(61310));
      for (int n = 0; n < NUM_DIR; n++) begin
         build_directed(n);
         run_program();
      end
      for (int n = 0; n < NUM_RAND; n++) begin
         build_random();
         run_program();
      end
      total = chk0.value_errors + chk0.missing_errors + chk0.extra_errors + chk0.reset_errors;
      $display("errors: value %0d, missing %0d, extra %0d, reset %0d",
               chk0.value_errors, chk0.missing_errors, chk0.extra_errors, chk0.reset_errors);
      if (total == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// ==== verilog/lc4_core.sv ====
`timescale 1ns/1ps

module lc4_core #(
   parameter lc4_isa_pkg::word_t P_RESET_PC = lc4_isa_pkg::RESET_PC
) (
   input  logic               gwe,
   input  logic               i_arst_n,
   output lc4_isa_pkg::word_t o_imem_addr,
   input  lc4_isa_pkg::word_t i_imem_data,
   output lc4_isa_pkg::word_t o_dmem_addr,
   output logic               o_dmem_we,
   output lc4_isa_pkg::word_t o_dmem_wdata,
   input  lc4_isa_pkg::word_t i_dmem_rdata
);
   import lc4_isa_pkg::*;
   import lc4_pipe_pkg::*;

   // fetch and hazard control
   word_t    f_pc;
   word_t    target;
   logic     stall;
   logic     redirect;
   byp_sel_t byp_a;
   byp_sel_t byp_b;
   // decode stage
   word_t    d_insn;
   word_t    d_pc;
   reg_sel_t d_rs;
   reg_sel_t d_rt;
   reg_sel_t d_rd;
   logic     d_rs_re;
   logic     d_rt_re;
   logic     d_reg_we;
   logic     d_nzp_we;
   logic     d_is_load;
   logic     d_is_store;
   logic     d_is_branch;
   logic     d_use_imm;
   word_t    d_imm;
   alu_op_t  d_alu_op;
   word_t    d_rs_data;
   word_t    d_rt_data;
   // execute stage
   reg_sel_t x_rs;
   reg_sel_t x_rt;
   reg_sel_t x_rd;
   logic     x_reg_we;
   logic     x_nzp_we;
   logic     x_is_load;
   logic     x_is_store;
   logic     x_is_branch;
   logic     x_use_imm;
   alu_op_t  x_alu_op;
   nzp_t     x_br_mask;
   word_t    x_rs_data;
   word_t    x_rt_data;
   word_t    x_imm;
   word_t    x_pc;
   word_t    x_result;
   word_t    x_store_data;
   // memory stage
   reg_sel_t m_rd;
   logic     m_reg_we;
   logic     m_nzp_we;
   logic     m_is_load;
   logic     m_is_store;
   word_t    m_result;
   word_t    m_store_data;
   // writeback stage
   reg_sel_t w_rd;
   logic     w_reg_we;
   logic     w_nzp_we;
   logic     w_is_load;
   word_t    w_result;
   word_t    w_load_data;
   word_t    w_wdata;

   lc4_fetch #(.P_RESET_PC(P_RESET_PC)) fetch0 (
      .gwe(gwe), .i_arst_n(i_arst_n), .i_stall(stall), .i_redirect(redirect),
      .i_target(target), .o_pc(f_pc), .o_pc_next_seq()
   );

   assign o_imem_addr = f_pc;

   // decode latch holds on stall, squashed by a taken branch
   always_ff @(posedge gwe or negedge i_arst_n) begin
      if (!i_arst_n) begin
         d_insn <= '0;
      end else if (redirect) begin
         d_insn <= '0;
      end else if (!stall) begin
         d_insn <= i_imem_data;
      end
   end

   always_ff @(posedge gwe) begin
      if (!stall) begin
         d_pc <= f_pc;
      end
   end

   lc4_decoder dec0 (
      .i_insn(d_insn), .o_rs(d_rs), .o_rt(d_rt), .o_rd(d_rd),
      .o_rs_re(d_rs_re), .o_rt_re(d_rt_re), .o_reg_we(d_reg_we), .o_nzp_we(d_nzp_we),
      .o_is_load(d_is_load), .o_is_store(d_is_store), .o_is_branch(d_is_branch),
      .o_use_imm(d_use_imm), .o_imm(d_imm), .o_alu_op(d_alu_op)
   );

   lc4_regfile rf0 (
      .gwe(gwe), .i_arst_n(i_arst_n), .i_rs(d_rs), .i_rt(d_rt), .i_rd(w_rd),
      .i_we(w_reg_we), .i_wdata(w_wdata), .o_rs_data(d_rs_data), .o_rt_data(d_rt_data)
   );

   lc4_hazard haz0 (
      .gwe(gwe), .i_arst_n(i_arst_n),
      .i_d_rs(d_rs), .i_d_rt(d_rt), .i_x_rs(x_rs), .i_x_rt(x_rt), .i_x_rd(x_rd),
      .i_m_rd(m_rd), .i_w_rd(w_rd), .i_d_rs_re(d_rs_re), .i_d_rt_re(d_rt_re),
      .i_d_is_branch(d_is_branch), .i_x_is_load(x_is_load), .i_m_reg_we(m_reg_we),
      .i_w_reg_we(w_reg_we), .o_stall(stall), .o_byp_a(byp_a), .o_byp_b(byp_b)
   );

   // execute latch, a stall or a flush sends in a bubble
   always_ff @(posedge gwe or negedge i_arst_n) begin
      if (!i_arst_n) begin
         {x_reg_we, x_nzp_we, x_is_load, x_is_store, x_is_branch} <= '0;
      end else if (stall || redirect) begin
         {x_reg_we, x_nzp_we, x_is_load, x_is_store, x_is_branch} <= '0;
      end else begin
         {x_reg_we, x_nzp_we, x_is_load, x_is_store, x_is_branch} <=
            {d_reg_we, d_nzp_we, d_is_load, d_is_store, d_is_branch};
      end
   end

   always_ff @(posedge gwe) begin
      x_rs      <= d_rs;
      x_rt      <= d_rt;
      x_rd      <= d_rd;
      x_use_imm <= d_use_imm;
      x_alu_op  <= d_alu_op;
      x_br_mask <= d_insn[POS_RD +: 3];
      x_rs_data <= d_rs_data;
      x_rt_data <= d_rt_data;
      x_imm     <= d_imm;
      x_pc      <= d_pc;
   end

   lc4_execute ex0 (
      .gwe(gwe), .i_arst_n(i_arst_n), .i_rs_data(x_rs_data), .i_rt_data(x_rt_data),
      .i_m_result(m_result), .i_w_result(w_wdata), .i_imm(x_imm), .i_pc(x_pc),
      .i_byp_a(byp_a), .i_byp_b(byp_b), .i_alu_op(x_alu_op), .i_use_imm(x_use_imm),
      .i_is_branch(x_is_branch), .i_m_nzp_we(m_nzp_we), .i_w_nzp_we(w_nzp_we),
      .i_br_mask(x_br_mask), .o_result(x_result), .o_store_data(x_store_data),
      .o_target(target), .o_redirect(redirect)
   );

   // memory latch
   always_ff @(posedge gwe or negedge i_arst_n) begin
      if (!i_arst_n) begin
         {m_reg_we, m_nzp_we, m_is_load, m_is_store} <= '0;
      end else begin
         {m_reg_we, m_nzp_we, m_is_load, m_is_store} <=
            {x_reg_we, x_nzp_we, x_is_load, x_is_store};
      end
   end

   always_ff @(posedge gwe) begin
      m_rd         <= x_rd;
      m_result     <= x_result;
      m_store_data <= x_store_data;
   end

   assign o_dmem_addr = m_result;
   assign o_dmem_we   = m_is_store;
   // a store's rt is carried in m_rd, a load just ahead in writeback feeds it
   assign o_dmem_wdata = (w_is_load && w_reg_we && w_rd == m_rd) ? w_wdata : m_store_data;

   // writeback latch
   always_ff @(posedge gwe or negedge i_arst_n) begin
      if (!i_arst_n) begin
         {w_reg_we, w_nzp_we, w_is_load} <= '0;
      end else begin
         {w_reg_we, w_nzp_we, w_is_load} <= {m_reg_we, m_nzp_we, m_is_load};
      end
   end

   always_ff @(posedge gwe) begin
      w_rd        <= m_rd;
      w_result    <= m_result;
      w_load_data <= i_dmem_rdata;
   end

   assign w_wdata = w_is_load ? w_load_data : w_result;

endmodule

// ==== verilog/lc4_decoder.sv ====
`timescale 1ns/1ps

module lc4_decoder (
   input  lc4_isa_pkg::word_t     i_insn,
   output lc4_isa_pkg::reg_sel_t  o_rs,
   output lc4_isa_pkg::reg_sel_t  o_rt,
   output lc4_isa_pkg::reg_sel_t  o_rd,
   output logic                   o_rs_re,
   output logic                   o_rt_re,
   output logic                   o_reg_we,
   output logic                   o_nzp_we,
   output logic                   o_is_load,
   output logic                   o_is_store,
   output logic                   o_is_branch,
   output logic                   o_use_imm,
   output lc4_isa_pkg::word_t     o_imm,
   output lc4_pipe_pkg::alu_op_t  o_alu_op
);
   import lc4_isa_pkg::*;
   import lc4_pipe_pkg::*;

   word_t      imm5;
   word_t      imm6;
   word_t      imm9;
   logic [2:0] sub;

   // sign-extended immediates of the three formats
   assign imm5 = {{(WORD_W-IMM5_W){i_insn[IMM5_W-1]}}, i_insn[IMM5_W-1:0]};
   assign imm6 = {{(WORD_W-IMM6_W){i_insn[IMM6_W-1]}}, i_insn[IMM6_W-1:0]};
   assign imm9 = {{(WORD_W-IMM9_W){i_insn[IMM9_W-1]}}, i_insn[IMM9_W-1:0]};
   assign sub  = i_insn[POS_SUB +: 3];

   always_comb begin
      o_rs        = i_insn[POS_RS +: REG_W];
      o_rt        = i_insn[POS_RT +: REG_W];
      o_rd        = i_insn[POS_RD +: REG_W];
      o_rs_re     = 1'b0;
      o_rt_re     = 1'b0;
      o_reg_we    = 1'b0;
      o_nzp_we    = 1'b0;
      o_is_load   = 1'b0;
      o_is_store  = 1'b0;
      o_is_branch = 1'b0;
      o_use_imm   = 1'b0;
      o_imm       = imm9;
      o_alu_op    = ALU_ADD;
      case (opcode_t'(i_insn[POS_OP +: 4]))
         // mask 000 is the nop
         OP_BR: o_is_branch = |i_insn[POS_RD +: 3];
         OP_ARITH: begin
            if (i_insn[POS_IMMF]) begin
               {o_rs_re, o_reg_we, o_nzp_we, o_use_imm} = 4'b1111;
               o_imm = imm5;
            end else if (sub == SUB_ADD || sub == SUB_SUB) begin
               {o_rs_re, o_rt_re, o_reg_we, o_nzp_we} = 4'b1111;
               o_alu_op = (sub == SUB_SUB) ? ALU_SUB : ALU_ADD;
            end
         end
         OP_LOGIC: begin
            // not and the immediate and stay nops
            if (!i_insn[POS_IMMF] && sub inside {SUB_AND, SUB_OR, SUB_XOR}) begin
               {o_rs_re, o_rt_re, o_reg_we, o_nzp_we} = 4'b1111;
               o_alu_op = (sub == SUB_AND) ? ALU_AND : (sub == SUB_OR) ? ALU_OR : ALU_XOR;
            end
         end
         OP_LDR: begin
            {o_rs_re, o_reg_we, o_nzp_we, o_is_load, o_use_imm} = 5'b11111;
            o_imm = imm6;
         end
         OP_STR: begin
            // store data sits in the rd field
            // rt_re stays low: store data may still be bypassed in the memory stage
            o_rt       = i_insn[POS_RD +: REG_W];
            o_rs_re    = 1'b1;
            o_is_store = 1'b1;
            o_use_imm  = 1'b1;
            o_imm      = imm6;
         end
         OP_CONST: begin
            {o_reg_we, o_nzp_we, o_use_imm} = 3'b111;
            o_alu_op = ALU_PASS_IMM;
         end
         default: ;
      endcase
   end

endmodule

// ==== verilog/lc4_execute.sv ====
`timescale 1ns/1ps

module lc4_execute (
   input  logic                   gwe,
   input  logic                   i_arst_n,
   input  lc4_isa_pkg::word_t     i_rs_data,
   input  lc4_isa_pkg::word_t     i_rt_data,
   input  lc4_isa_pkg::word_t     i_m_result,
   input  lc4_isa_pkg::word_t     i_w_result,
   input  lc4_isa_pkg::word_t     i_imm,
   input  lc4_isa_pkg::word_t     i_pc,
   input  lc4_pipe_pkg::byp_sel_t i_byp_a,
   input  lc4_pipe_pkg::byp_sel_t i_byp_b,
   input  lc4_pipe_pkg::alu_op_t  i_alu_op,
   input  logic                   i_use_imm,
   input  logic                   i_is_branch,
   input  logic                   i_m_nzp_we,
   input  logic                   i_w_nzp_we,
   input  lc4_isa_pkg::nzp_t      i_br_mask,
   output lc4_isa_pkg::word_t     o_result,
   output lc4_isa_pkg::word_t     o_store_data,
   output lc4_isa_pkg::word_t     o_target,
   output logic                   o_redirect
);
   import lc4_isa_pkg::*;
   import lc4_pipe_pkg::*;

   word_t opa;
   word_t opb_reg;
   word_t opb;
   nzp_t  nzp_q;
   nzp_t  nzp_byp;

   function automatic nzp_t nzp_of(input word_t v);
      if (v == '0) begin
         return NZP_Z;
      end
      return v[WORD_W-1] ? NZP_N : NZP_P;
   endfunction

   // operand bypass muxes
   always_comb begin
      case (i_byp_a)
         BYP_MEM: opa = i_m_result;
         BYP_WB:  opa = i_w_result;
         default: opa = i_rs_data;
      endcase
      case (i_byp_b)
         BYP_MEM: opb_reg = i_m_result;
         BYP_WB:  opb_reg = i_w_result;
         default: opb_reg = i_rt_data;
      endcase
   end

   assign opb = i_use_imm ? i_imm : opb_reg;

   always_comb begin
      case (i_alu_op)
         ALU_SUB:      o_result = opa - opb;
         ALU_AND:      o_result = opa & opb;
         ALU_OR:       o_result = opa | opb;
         ALU_XOR:      o_result = opa ^ opb;
         ALU_PASS_IMM: o_result = i_imm;
         default:      o_result = opa + opb;
      endcase
   end

   // store data is the bypassed rt, never the immediate
   assign o_store_data = opb_reg;

   // architectural nzp, updated as writeback retires
   always_ff @(posedge gwe or negedge i_arst_n) begin
      if (!i_arst_n) begin
         nzp_q <= NZP_Z;
      end else if (i_w_nzp_we) begin
         nzp_q <= nzp_of(i_w_result);
      end
   end

   // youngest nzp writer wins, same as the operand bypass
   assign nzp_byp = i_m_nzp_we ? nzp_of(i_m_result) :
                    i_w_nzp_we ? nzp_of(i_w_result) : nzp_q;

   assign o_redirect = i_is_branch & |(i_br_mask & nzp_byp);
   assign o_target   = i_pc + 16'd1 + i_imm;

endmodule

// ==== verilog/lc4_fetch.sv ====
`timescale 1ns/1ps

module lc4_fetch #(
   parameter lc4_isa_pkg::word_t P_RESET_PC = lc4_isa_pkg::RESET_PC
) (
   input  logic               gwe,
   input  logic               i_arst_n,
   input  logic               i_stall,
   input  logic               i_redirect,
   input  lc4_isa_pkg::word_t i_target,
   output lc4_isa_pkg::word_t o_pc,
   output lc4_isa_pkg::word_t o_pc_next_seq
);
   import lc4_isa_pkg::*;

   word_t pc_q;
   word_t pc_inc;

   assign pc_inc = pc_q + 16'd1;

   // a taken branch overrides a load-use hold
   always_ff @(posedge gwe or negedge i_arst_n) begin
      if (!i_arst_n) begin
         pc_q <= P_RESET_PC;
      end else if (i_redirect) begin
         pc_q <= i_target;
      end else if (!i_stall) begin
         pc_q <= pc_inc;
      end
   end

   assign o_pc          = pc_q;
   assign o_pc_next_seq = pc_inc;

   // the flush puts a bubble behind every taken branch, so no back-to-back redirect
   a_no_double_redirect : assert property (
      @(posedge gwe) disable iff (!i_arst_n) i_redirect |=> !i_redirect
   );

endmodule

// ==== verilog/lc4_hazard.sv ====
`timescale 1ns/1ps

module lc4_hazard (
   input  logic                   gwe,
   input  logic                   i_arst_n,
   input  lc4_isa_pkg::reg_sel_t  i_d_rs,
   input  lc4_isa_pkg::reg_sel_t  i_d_rt,
   input  lc4_isa_pkg::reg_sel_t  i_x_rs,
   input  lc4_isa_pkg::reg_sel_t  i_x_rt,
   input  lc4_isa_pkg::reg_sel_t  i_x_rd,
   input  lc4_isa_pkg::reg_sel_t  i_m_rd,
   input  lc4_isa_pkg::reg_sel_t  i_w_rd,
   input  logic                   i_d_rs_re,
   input  logic                   i_d_rt_re,
   input  logic                   i_d_is_branch,
   input  logic                   i_x_is_load,
   input  logic                   i_m_reg_we,
   input  logic                   i_w_reg_we,
   output logic                   o_stall,
   output lc4_pipe_pkg::byp_sel_t o_byp_a,
   output lc4_pipe_pkg::byp_sel_t o_byp_b
);
   import lc4_pipe_pkg::*;

   // load in execute, its data is only there after the memory stage
   // a branch waits too since the load's nzp comes from that data
   assign o_stall = i_x_is_load &
                    ((i_d_rs_re && i_d_rs == i_x_rd) ||
                     (i_d_rt_re && i_d_rt == i_x_rd) ||
                     i_d_is_branch);

   // youngest producer first
   assign o_byp_a = (i_m_reg_we && i_m_rd == i_x_rs) ? BYP_MEM :
                    (i_w_reg_we && i_w_rd == i_x_rs) ? BYP_WB  : BYP_REG;
   assign o_byp_b = (i_m_reg_we && i_m_rd == i_x_rt) ? BYP_MEM :
                    (i_w_reg_we && i_w_rd == i_x_rt) ? BYP_WB  : BYP_REG;

   // the stall bubble is no load, so the stall drops after one cycle
   a_single_stall : assert property (
      @(posedge gwe) disable iff (!i_arst_n) o_stall |=> !o_stall
   );

endmodule

// ==== verilog/lc4_isa_pkg.sv ====
package lc4_isa_pkg;

   // basic widths of the machine
   localparam int unsigned WORD_W = 16;
   localparam int unsigned REG_W  = 3;
   localparam int unsigned NUM_REGS = 8;

   typedef logic [WORD_W-1:0] word_t;
   typedef logic [REG_W-1:0]  reg_sel_t;
   // one-hot condition code, n z p from msb to lsb
   typedef logic [2:0]        nzp_t;

   localparam nzp_t NZP_N = 3'b100;
   localparam nzp_t NZP_Z = 3'b010;
   localparam nzp_t NZP_P = 3'b001;

   // only the opcodes this core executes, anything else is a nop
   typedef enum logic [3:0] {
      OP_BR    = 4'b0000,
      OP_ARITH = 4'b0001,
      OP_LOGIC = 4'b0101,
      OP_LDR   = 4'b0110,
      OP_STR   = 4'b0111,
      OP_CONST = 4'b1001
   } opcode_t;

   // field positions inside an instruction word
   localparam int unsigned POS_OP   = 12;
   localparam int unsigned POS_RD   = 9;
   localparam int unsigned POS_RS   = 6;
   localparam int unsigned POS_SUB  = 3;
   localparam int unsigned POS_RT   = 0;
   // bit 5 marks the immediate form of arith and logic
   localparam int unsigned POS_IMMF = 5;
   localparam int unsigned IMM5_W   = 5;
   localparam int unsigned IMM6_W   = 6;
   localparam int unsigned IMM9_W   = 9;

   // sub-function codes of the register forms
   localparam logic [2:0] SUB_ADD = 3'b000;
   localparam logic [2:0] SUB_SUB = 3'b010;
   localparam logic [2:0] SUB_AND = 3'b000;
   localparam logic [2:0] SUB_OR  = 3'b010;
   localparam logic [2:0] SUB_XOR = 3'b011;

   localparam word_t RESET_PC = 16'h8200;

endpackage

// ==== verilog/lc4_pipe_pkg.sv ====
package lc4_pipe_pkg;

   // where an execute operand comes from
   typedef enum logic [1:0] {
      // value read from the register file in decode
      BYP_REG = 2'd0,
      // result of the instruction in the memory stage
      BYP_MEM = 2'd1,
      // value being written back this cycle
      BYP_WB  = 2'd2
   } byp_sel_t;

   // alu function, chosen by the decoder
   typedef enum logic [2:0] {
      ALU_ADD      = 3'd0,
      ALU_SUB      = 3'd1,
      ALU_AND      = 3'd2,
      ALU_OR       = 3'd3,
      ALU_XOR      = 3'd4,
      // const just passes the sign-extended immediate through
      ALU_PASS_IMM = 3'd5
   } alu_op_t;

endpackage

// ==== verilog/lc4_regfile.sv ====
`timescale 1ns/1ps

module lc4_regfile (
   input  logic                  gwe,
   input  logic                  i_arst_n,
   input  lc4_isa_pkg::reg_sel_t i_rs,
   input  lc4_isa_pkg::reg_sel_t i_rt,
   input  lc4_isa_pkg::reg_sel_t i_rd,
   input  logic                  i_we,
   input  lc4_isa_pkg::word_t    i_wdata,
   output lc4_isa_pkg::word_t    o_rs_data,
   output lc4_isa_pkg::word_t    o_rt_data
);
   import lc4_isa_pkg::*;

   word_t regs [NUM_REGS];

   always_ff @(posedge gwe or negedge i_arst_n) begin
      if (!i_arst_n) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (i_we) begin
         regs[i_rd] <= i_wdata;
      end
   end

   // write-through, decode sees the value writeback stores this cycle
   assign o_rs_data = (i_we && i_rd == i_rs) ? i_wdata : regs[i_rs];
   assign o_rt_data = (i_we && i_rd == i_rt) ? i_wdata : regs[i_rt];

endmodule
